//--- verilog/ocyrus_pkg.sv
package ocyrus_pkg;

	// --------------------
	// link geometry
	localparam int WORD_WIDTH = 8; // bits per word, also the strobe period in clocks
	localparam int LANES = 4; // transmit lanes; single and double builds set 1 or 2
	localparam int LOCK_STROBES = 4; // strobes after reset before lock is reported

	localparam int BIT_CNT_WIDTH = $clog2(WORD_WIDTH);
	localparam int STB_CNT_WIDTH = $clog2(LOCK_STROBES + 1);
	localparam int RX_COUNT_WIDTH = 8; // received word counter, wraps at 256

	// --------------------
	// wishbone register map
	localparam int WB_ADR_WIDTH = 2;
	localparam int WB_DATA_WIDTH = 32;

	localparam logic [WB_ADR_WIDTH-1:0] ADR_TX_WORDS = 2'd0; // lane i in byte i
	localparam logic [WB_ADR_WIDTH-1:0] ADR_RX_WORD = 2'd1; // low byte only
	localparam logic [WB_ADR_WIDTH-1:0] ADR_STATUS = 2'd2; // address 3 reads zero

	typedef logic [WORD_WIDTH-1:0] lane_word_t;
	typedef lane_word_t [LANES-1:0] lane_words_t;

	// status register layout
	typedef struct packed {
		logic [15:0] rsvd_hi;
		logic [RX_COUNT_WIDTH-1:0] rx_count; // bits 15:8
		logic [6:0] rsvd_lo;
		logic locked; // bit 0
	} status_word_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_ADR_WIDTH-1:0] adr;
		logic [WB_DATA_WIDTH-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WB_DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

endpackage

//--- verilog/serdes_strobe_gen.sv
`timescale 1ns/1ps

// word strobe and lock flag, standing in for the clock generator outputs

module serdes_strobe_gen (
	input logic clock,
	input logic rst_n,
	output logic word_strobe,
	output logic locked
);
	import ocyrus_pkg::*;

	logic [BIT_CNT_WIDTH-1:0] bit_cnt; // position within the current word
	logic [STB_CNT_WIDTH-1:0] strobe_cnt; // strobes seen since reset
	logic last_bit;

	// --------------------
	// bit counter

	assign last_bit = (bit_cnt == BIT_CNT_WIDTH'(WORD_WIDTH - 1));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (last_bit) begin
			bit_cnt <= '0; // start of the next word
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// one clock wide, in the last bit slot of every word
	assign word_strobe = last_bit;

	// --------------------
	// lock sequencer

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			strobe_cnt <= '0;
			locked <= 1'b0;
		end else if (word_strobe && !locked) begin
			strobe_cnt <= strobe_cnt + 1'b1; // stops counting once locked
			if (strobe_cnt == STB_CNT_WIDTH'(LOCK_STROBES - 1)) begin
				locked <= 1'b1; // held until the next reset
			end
		end
	end

	// strobe_cnt ends at LOCK_STROBES and stays there while locked
	// so a late strobe cannot wrap it back round

endmodule

//--- verilog/oserdes_lane.sv
`timescale 1ns/1ps

// one parallel to serial lane, MSB first

module oserdes_lane (
	input logic clock,
	input logic rst_n,
	input logic word_strobe,
	input logic locked,
	input ocyrus_pkg::lane_word_t word,
	output logic d_out
);
	import ocyrus_pkg::*;

	lane_word_t load_word; // word taken on the strobe
	lane_word_t shift_reg; // bits still to go out, next one in the MSB

	// nothing but zeros leave the lane until the link is locked
	assign load_word = locked ? word : '0;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			shift_reg <= '0;
			d_out <= 1'b0;
		end else if (word_strobe) begin
			d_out <= load_word[WORD_WIDTH-1]; // MSB goes out straight away
			shift_reg <= {load_word[WORD_WIDTH-2:0], 1'b0};
		end else begin
			d_out <= shift_reg[WORD_WIDTH-1];
			shift_reg <= {shift_reg[WORD_WIDTH-2:0], 1'b0}; // shift left
		end
	end

	// the LSB leaves in the strobe cycle of the next word, so frames
	// follow each other with no gap

endmodule

//--- verilog/iserdes_lane.sv
`timescale 1ns/1ps

// serial to parallel receiver, one word per strobe

module iserdes_lane (
	input logic clock,
	input logic rst_n,
	input logic word_strobe,
	input logic data_in,
	output ocyrus_pkg::lane_word_t rx_word,
	output logic rx_valid
);
	import ocyrus_pkg::*;

	lane_word_t shift_reg; // last bits sampled, newest in the LSB
	lane_word_t frame; // the word as of this clock

	// newest bit enters at the LSB end, oldest ends up as the MSB
	assign frame = {shift_reg[WORD_WIDTH-2:0], data_in};

	// --------------------
	// sampling

	always_ff @(posedge clock) begin
		shift_reg <= frame; // samples every clock, reset or not
	end

	// --------------------
	// word capture

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rx_word <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= word_strobe; // one clock after the capture edge
			if (word_strobe) begin
				rx_word <= frame;
			end
		end
	end

	// rx_word holds until the next strobe, so the register block can read
	// it at any time within the frame

endmodule

//--- verilog/ocyrus_regs.sv
`timescale 1ns/1ps

// wishbone classic register block steering the serdes lanes

module ocyrus_regs (
	input logic clock,
	input logic rst_n,
	input ocyrus_pkg::wb_req_t wb_req,
	output ocyrus_pkg::wb_rsp_t wb_rsp,
	input logic locked,
	input logic rx_valid,
	input ocyrus_pkg::lane_word_t rx_word,
	output ocyrus_pkg::lane_words_t tx_words
);
	import ocyrus_pkg::*;

	logic ack; // single cycle acknowledge
	logic req_seen; // new request this cycle
	logic wr_en;
	logic [WB_DATA_WIDTH-1:0] rd_mux;
	logic [WB_DATA_WIDTH-1:0] rd_data; // held for the ack cycle
	logic [RX_COUNT_WIDTH-1:0] rx_count;
	status_word_t status;

	// --------------------
	// bus handshake

	// a request is only taken while ack is low, so each one is acked once
	assign req_seen = wb_req.cyc && wb_req.stb && !ack;
	assign wr_en = req_seen && wb_req.we;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req_seen; // drops again the next cycle
		end
	end

	// --------------------
	// transmit words

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tx_words <= '0;
		end else if (wr_en && (wb_req.adr == ADR_TX_WORDS)) begin
			tx_words <= lane_words_t'(wb_req.dat); // lane i from byte i
		end
	end

	// writes to the other addresses are acked and dropped

	// --------------------
	// received word count

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rx_count <= '0;
		end else if (rx_valid) begin
			rx_count <= rx_count + 1'b1; // wraps at 256
		end
	end

	always_comb begin
		status = '0;
		status.locked = locked;
		status.rx_count = rx_count;
	end

	// read decode

	always_comb begin
		rd_mux = '0;
		case (wb_req.adr)
			ADR_TX_WORDS: begin
				rd_mux = tx_words;
			end
			ADR_RX_WORD: begin
				rd_mux = WB_DATA_WIDTH'(rx_word); // upper bytes zero
			end
			ADR_STATUS: begin
				rd_mux = status;
			end
			default: begin
				rd_mux = '0; // address 3 unused
			end
		endcase
	end

	// read data is captured on the request edge and shown with ack
	always_ff @(posedge clock) begin
		if (req_seen) begin
			rd_data <= rd_mux;
		end
	end

	assign wb_rsp = '{ack: ack, dat: rd_data};

endmodule

//--- verilog/ocyrus_quad.sv
`timescale 1ns/1ps

// four lane serializer link with one receive lane and a wishbone
// register block, all in the fabric clock domain

module ocyrus_quad (
	input logic clock,
	input logic rst_n,
	input ocyrus_pkg::wb_req_t wb_req,
	output ocyrus_pkg::wb_rsp_t wb_rsp,
	input logic data_in,
	output logic [ocyrus_pkg::LANES-1:0] d_out
);
	import ocyrus_pkg::*;

	logic word_strobe; // last bit slot of each word
	logic locked; // stand-in for the clock generator lock
	lane_words_t tx_words; // lane i in byte i
	lane_word_t rx_word;
	logic rx_valid;

	// --------------------
	// strobe and lock

	serdes_strobe_gen u_strobe_gen (
		.clock       (clock),
		.rst_n       (rst_n),
		.word_strobe (word_strobe),
		.locked      (locked)
	);

	// --------------------
	// transmit lanes

	// all lanes share one strobe so their frames stay aligned
	for (genvar i = 0; i < LANES; i++) begin : g_tx_lane
		oserdes_lane u_tx_lane (
			.clock       (clock),
			.rst_n       (rst_n),
			.word_strobe (word_strobe),
			.locked      (locked),
			.word        (tx_words[i]),
			.d_out       (d_out[i])
		);
	end

	// --------------------
	// receive lane

	iserdes_lane u_rx_lane (
		.clock       (clock),
		.rst_n       (rst_n),
		.word_strobe (word_strobe),
		.data_in     (data_in),
		.rx_word     (rx_word),
		.rx_valid    (rx_valid)
	);

	// --------------------
	// register block

	ocyrus_regs u_regs (
		.clock    (clock),
		.rst_n    (rst_n),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.locked   (locked),
		.rx_valid (rx_valid),
		.rx_word  (rx_word),
		.tx_words (tx_words)
	);

	// a word written to TX_WORDS goes out on the first strobe after the
	// write, one frame slot later, once lock is up

endmodule

//--- sim/ocyrus_tb_model.svh
`ifndef OCYRUS_TB_MODEL_SVH
`define OCYRUS_TB_MODEL_SVH

// cycle model of the link, advanced once per rising edge after reset release

int m_cycle; // edges since reset release
int m_strobes; // strobes seen, stops at LOCK_STROBES
logic m_locked;
logic m_ack;
logic [WB_DATA_WIDTH-1:0] m_rd_data; // data expected while ack is high
lane_words_t m_tx_words;
lane_words_t m_frame; // words now on the serial lanes
int m_bit_pos; // bit of m_frame on d_out, 0 is the MSB
lane_word_t m_rx_shift; // last data_in bits, newest in the LSB
lane_word_t m_rx_word;
logic m_rx_valid;
logic [7:0] m_rx_count;

function automatic void reset_model();
	m_cycle = 0;
	m_strobes = 0;
	m_locked = 1'b0;
	m_ack = 1'b0;
	m_rd_data = '0;
	m_tx_words = '0;
	m_frame = '0;
	m_bit_pos = 0;
	m_rx_shift = '0;
	m_rx_word = '0;
	m_rx_valid = 1'b0;
	m_rx_count = '0;
endfunction

// strobe sits in the last bit slot of each word
function automatic logic is_strobe_cycle(input int n);
	return (n % WORD_WIDTH) == (WORD_WIDTH - 1);
endfunction

function automatic logic [WB_DATA_WIDTH-1:0] predict_read(input logic [WB_ADR_WIDTH-1:0] adr);
	logic [WB_DATA_WIDTH-1:0] value;
	value = '0;
	if (adr == ADR_TX_WORDS) begin
		value = m_tx_words;
	end else if (adr == ADR_RX_WORD) begin
		value[7:0] = m_rx_word;
	end else if (adr == ADR_STATUS) begin
		value[0] = m_locked;
		value[15:8] = m_rx_count;
	end
	return value; // address 3 stays zero
endfunction

// state as seen before the edge decides everything taken on that edge
function automatic void advance_model(input wb_req_t req, input logic din);
	logic strobe;
	logic seen;
	strobe = is_strobe_cycle(m_cycle);
	seen = req.cyc && req.stb && !m_ack;
	if (seen) begin
		m_rd_data = predict_read(req.adr);
	end
	if (m_rx_valid) begin
		m_rx_count = m_rx_count + 8'd1;
	end
	m_rx_valid = strobe;
	m_rx_shift = {m_rx_shift[WORD_WIDTH-2:0], din};
	if (strobe) begin
		m_rx_word = m_rx_shift; // oldest of the 8 bits lands in the MSB
		m_frame = m_locked ? m_tx_words : '0;
		m_bit_pos = 0;
		if (m_strobes < LOCK_STROBES) begin
			m_strobes++;
		end
		if (m_strobes == LOCK_STROBES) begin
			m_locked = 1'b1;
		end
	end else if (m_bit_pos < WORD_WIDTH - 1) begin
		m_bit_pos++;
	end
	if (seen && req.we && (req.adr == ADR_TX_WORDS)) begin
		m_tx_words = req.dat;
	end
	m_ack = seen;
	m_cycle++;
endfunction

function automatic logic [LANES-1:0] predict_d_out();
	logic [LANES-1:0] bits;
	for (int i = 0; i < LANES; i++) begin
		bits[i] = m_frame[i][WORD_WIDTH-1-m_bit_pos];
	end
	return bits;
endfunction

`endif

//--- sim/ocyrus_quad_tb.sv
`timescale 1ns/1ps

module ocyrus_quad_tb;
	import ocyrus_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 2;
	localparam int DRIVE_DELAY = 1; // inputs change this long after the edge
	localparam int NUM_FRAMES = 64;
	localparam int WATCHDOG_NS = NUM_FRAMES * WORD_WIDTH * CLK_PERIOD * 2;
	localparam int ACK_LIMIT = 4; // cycles a request may wait for ack

	logic clock;
	logic rst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic data_in;
	logic [LANES-1:0] d_out;

	int unlocked_status_reads;
	int locked_status_reads;

	`include "ocyrus_tb_model.svh"

	ocyrus_quad u_dut (
		.clock   (clock),
		.rst_n   (rst_n),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.data_in (data_in),
		.d_out   (d_out)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// --------------------
	// reporting

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Error at time %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual));
		end
	endtask

	// one edge: model takes the inputs the DUT saw, outputs are compared
	task automatic advance_clock();
		@(posedge clock);
		#(DRIVE_DELAY);
		advance_model(wb_req, data_in);
		check_value("wb_rsp.ack", 32'(m_ack), 32'(wb_rsp.ack));
		check_value("d_out", 32'(predict_d_out()), 32'(d_out));
		if (m_ack) begin
			check_value("wb_rsp.dat", m_rd_data, wb_rsp.dat);
		end
		data_in = 1'($urandom()); // new serial bit every cycle
	endtask

	// --------------------
	// wishbone master

	task automatic bus_cycle(input logic we, input logic [WB_ADR_WIDTH-1:0] adr,
			input logic [WB_DATA_WIDTH-1:0] wdata, output logic [WB_DATA_WIDTH-1:0] rdata);
		int waited;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = wdata;
		waited = 0;
		do begin
			advance_clock();
			waited++;
			if (!wb_rsp.ack && (waited >= ACK_LIMIT)) begin
				stop_with_failure($sformatf("Request to address %0d was never acknowledged", adr));
			end
		end while (!wb_rsp.ack);
		rdata = wb_rsp.dat;
		wb_req = '0; // held only until ack
	endtask

	task automatic write_reg(input logic [WB_ADR_WIDTH-1:0] adr,
			input logic [WB_DATA_WIDTH-1:0] wdata);
		logic [WB_DATA_WIDTH-1:0] unused_data;
		bus_cycle(1'b1, adr, wdata, unused_data);
	endtask

	task automatic read_reg(input logic [WB_ADR_WIDTH-1:0] adr,
			output logic [WB_DATA_WIDTH-1:0] rdata);
		bus_cycle(1'b0, adr, '0, rdata);
		if (adr == ADR_STATUS) begin
			if (rdata[0]) begin
				locked_status_reads++;
			end else begin
				unlocked_status_reads++;
			end
		end
	endtask

	// --------------------
	// test sequence

	initial begin : main_seq
		logic [WB_DATA_WIDTH-1:0] rdata;
		logic [WB_DATA_WIDTH-1:0] wdata;
		logic [WB_ADR_WIDTH-1:0] ro_adr;
		int op;
		void'($urandom(79468));
		clock = 1'b0;
		rst_n = 1'b0;
		wb_req = '0;
		data_in = 1'b0;
		unlocked_status_reads = 0;
		locked_status_reads = 0;
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		reset_model();
		check_value("wb_rsp.ack", 32'd0, 32'(wb_rsp.ack));
		check_value("d_out", 32'd0, 32'(d_out));
		data_in = 1'($urandom());

		// still unlocked here, lanes must send zeros
		read_reg(ADR_TX_WORDS, rdata);
		check_value("TX_WORDS after reset", 32'd0, rdata);
		read_reg(ADR_STATUS, rdata);
		check_value("STATUS after reset", 32'd0, rdata);
		wdata = $urandom();
		write_reg(ADR_TX_WORDS, wdata);
		read_reg(ADR_TX_WORDS, rdata);
		check_value("TX_WORDS readback", wdata, rdata);
		write_reg(ADR_STATUS, $urandom());
		write_reg(ADR_RX_WORD, $urandom());
		read_reg(ADR_STATUS, rdata);
		read_reg(2'd3, rdata);
		check_value("address 3", 32'd0, rdata);

		while (m_cycle < NUM_FRAMES * WORD_WIDTH) begin
			op = int'($urandom_range(0, 7));
			case (op)
				0, 1: begin
					wdata = $urandom();
					write_reg(ADR_TX_WORDS, wdata);
					read_reg(ADR_TX_WORDS, rdata);
					check_value("TX_WORDS readback", wdata, rdata);
				end
				2: read_reg(ADR_TX_WORDS, rdata);
				3: read_reg(ADR_RX_WORD, rdata);
				4: read_reg(ADR_STATUS, rdata);
				5: begin
					ro_adr = ($urandom_range(0, 1) != 0) ? ADR_RX_WORD : ADR_STATUS;
					write_reg(ro_adr, $urandom()); // acked, no effect
				end
				6: begin
					read_reg(2'd3, rdata);
					check_value("address 3", 32'd0, rdata);
				end
				default: begin
					repeat ($urandom_range(1, 6)) advance_clock();
				end
			endcase
		end

		if ((unlocked_status_reads == 0) || (locked_status_reads == 0)) begin
			stop_with_failure("STATUS was not read both before and after lock");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	// --------------------
	// watchdog

	initial begin : watchdog
		#(WATCHDOG_NS);
		stop_with_failure($sformatf("Timeout: the run did not finish within %0d ns",
			WATCHDOG_NS));
	end

endmodule

//--- ocyrus_quad.f
+incdir+sim
verilog/ocyrus_pkg.sv
verilog/serdes_strobe_gen.sv
verilog/oserdes_lane.sv
verilog/iserdes_lane.sv
verilog/ocyrus_regs.sv
verilog/ocyrus_quad.sv
sim/ocyrus_quad_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the ocyrus_quad testbench with Verilator and run it.
# The run counts as passed only if the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-f ocyrus_quad.f \
	--top-module ocyrus_quad_tb \
	-Mdir obj_dir \
	-o ocyrus_quad_tb \
	&& { sim_out=$(./obj_dir/ocyrus_quad_tb 2>&1); echo "$sim_out"; } \
	&& grep -qx "Test OK" <<< "$sim_out" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

exit 0
